/* design/coreParamsPkg.sv */
`default_nettype none

package coreParamsPkg;

    // Issue width and execution units behind each port
    localparam int NUM_PORTS = 2;
    localparam int NUM_XUS = 2;

    localparam int DATA_W = 32;

    // Sequence numbers wrap, compared by signed difference
    localparam int SQN_W = 6;

    // Tag MSB marks a sign-extended constant in the low bits
    localparam int TAG_W = 7;
    localparam int REG_AW = TAG_W - 1;
    localparam int NUM_REGS = 64;

    // Two source reads per port
    localparam int NUM_RF_READS = 2 * NUM_PORTS;

    // aluFwd, exOut and wb buses of every port
    localparam int NUM_FWD_SRCS = 3 * NUM_PORTS;

endpackage

`default_nettype wire

/* design/uopTypesPkg.sv */
`default_nettype none

package uopTypesPkg;

    typedef logic [coreParamsPkg::TAG_W-1:0] Tag_t;
    typedef logic [coreParamsPkg::DATA_W-1:0] Data_t;
    typedef logic [coreParamsPkg::SQN_W-1:0] SqN_t;
    typedef logic [coreParamsPkg::NUM_XUS-1:0] XuMask_t;

    // Enum value doubles as the bit index in enableXU
    typedef enum logic {
        FU_INT,
        FU_MUL
    } FuncUnit_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        MUL,
        MULH
    } AluOp_t;

    typedef struct packed {
        Tag_t tagA;
        Tag_t tagB;
        Tag_t tagDst;
        Data_t imm;
        logic immB;
        AluOp_t opcode;
        FuncUnit_t fu;
        SqN_t sqN;
    } IssueUop_t;

    typedef struct packed {
        Data_t srcA;
        Data_t srcB;
        Tag_t tagDst;
        AluOp_t opcode;
        SqN_t sqN;
    } ExUop_t;

    // True when a is younger than b, wraparound safe
    function automatic logic isYounger(SqN_t a, SqN_t b);
        SqN_t diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

/* design/backendIfs.sv */
`default_nettype none

// Micro-op handed from operand fetch to execute
interface exUopIf;
    logic valid;
    uopTypesPkg::XuMask_t enableXU;
    uopTypesPkg::ExUop_t uop;
    logic stall;

    modport source (
        output valid,
        output enableXU,
        output uop,
        input stall
    );

    modport sink (
        input valid,
        input enableXU,
        input uop,
        output stall
    );
endinterface

// Result bus, valid for a single cycle per result
interface resultIf;
    logic valid;
    uopTypesPkg::Tag_t tag;
    uopTypesPkg::Data_t result;
    uopTypesPkg::SqN_t sqN;

    modport source (output valid, output tag, output result, output sqN);
    modport sink (input valid, input tag, input result, input sqN);
endinterface

`default_nettype wire

/* design/regFile.sv */
`default_nettype none

module regFile (
    input logic clk,
    input logic rst,
    input logic [coreParamsPkg::REG_AW-1:0] readAddr [coreParamsPkg::NUM_RF_READS],
    output uopTypesPkg::Data_t readData [coreParamsPkg::NUM_RF_READS],
    resultIf.sink wb [coreParamsPkg::NUM_PORTS]
);

    uopTypesPkg::Data_t regs [coreParamsPkg::NUM_REGS];

    logic wrEn [coreParamsPkg::NUM_PORTS];
    logic [coreParamsPkg::REG_AW-1:0] wrAddr [coreParamsPkg::NUM_PORTS];
    uopTypesPkg::Data_t wrData [coreParamsPkg::NUM_PORTS];

    for (genvar g = 0; g < coreParamsPkg::NUM_PORTS; g++) begin : gWrPort
        // Constant tags never name a register
        assign wrEn[g] = wb[g].valid && !wb[g].tag[coreParamsPkg::TAG_W-1];
        assign wrAddr[g] = wb[g].tag[coreParamsPkg::REG_AW-1:0];
        assign wrData[g] = wb[g].result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < coreParamsPkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Higher port wins on a same-register write
            for (int p = 0; p < coreParamsPkg::NUM_PORTS; p++) begin
                if (wrEn[p]) begin
                    regs[wrAddr[p]] <= wrData[p];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < coreParamsPkg::NUM_RF_READS; i++) begin
            readData[i] = regs[readAddr[i]];
        end
    end

endmodule

`default_nettype wire

/* design/operandLoad.sv */
`default_nettype none

module operandLoad (
    input logic clk,
    input logic rst,
    input logic uopValid [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::IssueUop_t uop [coreParamsPkg::NUM_PORTS],
    input logic flush,
    input uopTypesPkg::SqN_t flushSqN,
    output logic [coreParamsPkg::REG_AW-1:0] rfReadAddr [coreParamsPkg::NUM_RF_READS],
    input uopTypesPkg::Data_t rfReadData [coreParamsPkg::NUM_RF_READS],
    resultIf.sink aluFwd [coreParamsPkg::NUM_PORTS],
    resultIf.sink exOut [coreParamsPkg::NUM_PORTS],
    resultIf.sink wb [coreParamsPkg::NUM_PORTS],
    exUopIf.source exUop [coreParamsPkg::NUM_PORTS]
);

    // Forward sources, lowest index has highest priority
    logic fwdValid [coreParamsPkg::NUM_FWD_SRCS];
    uopTypesPkg::Tag_t fwdTag [coreParamsPkg::NUM_FWD_SRCS];
    uopTypesPkg::Data_t fwdData [coreParamsPkg::NUM_FWD_SRCS];

    logic stall [coreParamsPkg::NUM_PORTS];
    logic accept [coreParamsPkg::NUM_PORTS];
    logic kill [coreParamsPkg::NUM_PORTS];
    uopTypesPkg::Data_t srcA [coreParamsPkg::NUM_PORTS];
    uopTypesPkg::Data_t srcB [coreParamsPkg::NUM_PORTS];

    logic outValid [coreParamsPkg::NUM_PORTS];
    uopTypesPkg::XuMask_t outEnable [coreParamsPkg::NUM_PORTS];
    uopTypesPkg::ExUop_t outUop [coreParamsPkg::NUM_PORTS];

    // Constant tag, else newest forwarded value, else RF data
    function automatic uopTypesPkg::Data_t resolveOperand(uopTypesPkg::Tag_t tag,
                                                         uopTypesPkg::Data_t rfData);
        uopTypesPkg::Data_t value;
        logic found;
        value = rfData;
        found = 1'b0;
        if (tag[coreParamsPkg::TAG_W-1]) begin
            value = {{(coreParamsPkg::DATA_W - coreParamsPkg::REG_AW){tag[coreParamsPkg::REG_AW-1]}},
                     tag[coreParamsPkg::REG_AW-1:0]};
        end else begin
            for (int s = 0; s < coreParamsPkg::NUM_FWD_SRCS; s++) begin
                if (!found && fwdValid[s] && fwdTag[s] == tag) begin
                    value = fwdData[s];
                    found = 1'b1;
                end
            end
        end
        return value;
    endfunction

    for (genvar g = 0; g < coreParamsPkg::NUM_PORTS; g++) begin : gPort
        assign fwdValid[g] = aluFwd[g].valid;
        assign fwdTag[g] = aluFwd[g].tag;
        assign fwdData[g] = aluFwd[g].result;
        assign fwdValid[coreParamsPkg::NUM_PORTS + g] = exOut[g].valid;
        assign fwdTag[coreParamsPkg::NUM_PORTS + g] = exOut[g].tag;
        assign fwdData[coreParamsPkg::NUM_PORTS + g] = exOut[g].result;
        assign fwdValid[2 * coreParamsPkg::NUM_PORTS + g] = wb[g].valid;
        assign fwdTag[2 * coreParamsPkg::NUM_PORTS + g] = wb[g].tag;
        assign fwdData[2 * coreParamsPkg::NUM_PORTS + g] = wb[g].result;

        assign stall[g] = exUop[g].stall;
        assign exUop[g].valid = outValid[g];
        assign exUop[g].enableXU = outEnable[g];
        assign exUop[g].uop = outUop[g];
    end

    always_comb begin
        for (int p = 0; p < coreParamsPkg::NUM_PORTS; p++) begin
            rfReadAddr[p] = uop[p].tagA[coreParamsPkg::REG_AW-1:0];
            rfReadAddr[p + coreParamsPkg::NUM_PORTS] = uop[p].tagB[coreParamsPkg::REG_AW-1:0];
            srcA[p] = resolveOperand(uop[p].tagA, rfReadData[p]);
            // Immediate takes the place of the second source
            srcB[p] = uop[p].immB ? uop[p].imm
                : resolveOperand(uop[p].tagB, rfReadData[p + coreParamsPkg::NUM_PORTS]);
            accept[p] = uopValid[p] && !stall[p]
                && !(flush && uopTypesPkg::isYounger(uop[p].sqN, flushSqN));
            // Held op squashed even while stalled
            kill[p] = outValid[p] && flush && uopTypesPkg::isYounger(outUop[p].sqN, flushSqN);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < coreParamsPkg::NUM_PORTS; p++) begin
                outValid[p] <= 1'b0;
                outEnable[p] <= '0;
            end
        end else begin
            for (int p = 0; p < coreParamsPkg::NUM_PORTS; p++) begin
                if (accept[p]) begin
                    outValid[p] <= 1'b1;
                    outEnable[p] <= uopTypesPkg::XuMask_t'(1) << uop[p].fu;
                end else if (!stall[p] || kill[p]) begin
                    outValid[p] <= 1'b0;
                    outEnable[p] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < coreParamsPkg::NUM_PORTS; p++) begin
            if (accept[p]) begin
                outUop[p].srcA <= srcA[p];
                outUop[p].srcB <= srcB[p];
                outUop[p].tagDst <= uop[p].tagDst;
                outUop[p].opcode <= uop[p].opcode;
                outUop[p].sqN <= uop[p].sqN;
            end
        end
    end

endmodule

`default_nettype wire

/* design/execUnit.sv */
`default_nettype none

module execUnit (
    input logic clk,
    input logic rst,
    exUopIf.sink exUop,
    input logic flush,
    input uopTypesPkg::SqN_t flushSqN,
    resultIf.source aluFwd,
    resultIf.source exOut
);

    logic isAlu;
    logic isMul;
    logic aluGo;
    logic mulGo;
    logic mulLive;
    uopTypesPkg::Data_t aluResult;
    logic signed [2*coreParamsPkg::DATA_W-1:0] product;

    // Multiplier stage 1
    logic mulValid;
    uopTypesPkg::Data_t mulResult;
    uopTypesPkg::Tag_t mulTag;
    uopTypesPkg::SqN_t mulSqN;

    logic exValid;
    uopTypesPkg::Tag_t exTag;
    uopTypesPkg::Data_t exResult;
    uopTypesPkg::SqN_t exSqN;

    assign isAlu = exUop.valid && exUop.enableXU[uopTypesPkg::FU_INT];
    assign isMul = exUop.valid && exUop.enableXU[uopTypesPkg::FU_MUL];

    // ALU op and stage-1 product would both hit exOut next edge
    assign exUop.stall = mulValid && isAlu;

    assign aluGo = isAlu && !exUop.stall
        && !(flush && uopTypesPkg::isYounger(exUop.uop.sqN, flushSqN));
    assign mulGo = isMul && !(flush && uopTypesPkg::isYounger(exUop.uop.sqN, flushSqN));
    assign mulLive = mulValid && !(flush && uopTypesPkg::isYounger(mulSqN, flushSqN));

    always_comb begin
        case (exUop.uop.opcode)
            uopTypesPkg::ADD: aluResult = exUop.uop.srcA + exUop.uop.srcB;
            uopTypesPkg::SUB: aluResult = exUop.uop.srcA - exUop.uop.srcB;
            uopTypesPkg::AND: aluResult = exUop.uop.srcA & exUop.uop.srcB;
            uopTypesPkg::OR: aluResult = exUop.uop.srcA | exUop.uop.srcB;
            uopTypesPkg::XOR: aluResult = exUop.uop.srcA ^ exUop.uop.srcB;
            uopTypesPkg::SLL: aluResult = exUop.uop.srcA << exUop.uop.srcB[4:0];
            uopTypesPkg::SRL: aluResult = exUop.uop.srcA >> exUop.uop.srcB[4:0];
            default: aluResult = '0;
        endcase
    end

    // Signed product, MULH keeps the upper half
    assign product = $signed(exUop.uop.srcA) * $signed(exUop.uop.srcB);

    always_ff @(posedge clk) begin
        if (rst) begin
            mulValid <= 1'b0;
            exValid <= 1'b0;
        end else begin
            mulValid <= mulGo;
            exValid <= mulLive || aluGo;
        end
    end

    always_ff @(posedge clk) begin
        if (isMul) begin
            if (exUop.uop.opcode == uopTypesPkg::MULH) begin
                mulResult <= product[2*coreParamsPkg::DATA_W-1:coreParamsPkg::DATA_W];
            end else begin
                mulResult <= product[coreParamsPkg::DATA_W-1:0];
            end
            mulTag <= exUop.uop.tagDst;
            mulSqN <= exUop.uop.sqN;
        end
    end

    always_ff @(posedge clk) begin
        if (mulValid) begin
            exTag <= mulTag;
            exResult <= mulResult;
            exSqN <= mulSqN;
        end else begin
            exTag <= exUop.uop.tagDst;
            exResult <= aluResult;
            exSqN <= exUop.uop.sqN;
        end
    end

    // Forward whatever lands on exOut at the next edge
    assign aluFwd.valid = mulValid || isAlu;
    assign aluFwd.tag = mulValid ? mulTag : exUop.uop.tagDst;
    assign aluFwd.result = mulValid ? mulResult : aluResult;
    assign aluFwd.sqN = mulValid ? mulSqN : exUop.uop.sqN;

    assign exOut.valid = exValid;
    assign exOut.tag = exTag;
    assign exOut.result = exResult;
    assign exOut.sqN = exSqN;

endmodule

`default_nettype wire

/* design/writebackStage.sv */
`default_nettype none

module writebackStage (
    input logic clk,
    input logic rst,
    resultIf.sink exOut [coreParamsPkg::NUM_PORTS],
    input logic flush,
    input uopTypesPkg::SqN_t flushSqN,
    resultIf.source wb [coreParamsPkg::NUM_PORTS]
);

    for (genvar g = 0; g < coreParamsPkg::NUM_PORTS; g++) begin : gPort
        logic keep;
        logic wbValid;
        uopTypesPkg::Tag_t wbTag;
        uopTypesPkg::Data_t wbResult;
        uopTypesPkg::SqN_t wbSqN;

        // Results of squashed ops never leave the core
        assign keep = exOut[g].valid
            && !(flush && uopTypesPkg::isYounger(exOut[g].sqN, flushSqN));

        always_ff @(posedge clk) begin
            if (rst) begin
                wbValid <= 1'b0;
            end else begin
                wbValid <= keep;
            end
        end

        always_ff @(posedge clk) begin
            wbTag <= exOut[g].tag;
            wbResult <= exOut[g].result;
            wbSqN <= exOut[g].sqN;
        end

        assign wb[g].valid = wbValid;
        assign wb[g].tag = wbTag;
        assign wb[g].result = wbResult;
        assign wb[g].sqN = wbSqN;
    end

endmodule

`default_nettype wire

/* design/backendCore.sv */
`default_nettype none

module backendCore (
    input logic clk,
    input logic rst,
    input logic issueValid [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::Tag_t issueTagA [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::Tag_t issueTagB [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::Tag_t issueTagDst [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::Data_t issueImm [coreParamsPkg::NUM_PORTS],
    input logic issueImmB [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::AluOp_t issueOpcode [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::FuncUnit_t issueFu [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::SqN_t issueSqN [coreParamsPkg::NUM_PORTS],
    output logic issueStall [coreParamsPkg::NUM_PORTS],
    output logic wbValid [coreParamsPkg::NUM_PORTS],
    output uopTypesPkg::Tag_t wbTag [coreParamsPkg::NUM_PORTS],
    output uopTypesPkg::Data_t wbResult [coreParamsPkg::NUM_PORTS],
    output uopTypesPkg::SqN_t wbSqN [coreParamsPkg::NUM_PORTS],
    input logic flush,
    input uopTypesPkg::SqN_t flushSqN
);

    uopTypesPkg::IssueUop_t issueUop [coreParamsPkg::NUM_PORTS];
    logic [coreParamsPkg::REG_AW-1:0] rfReadAddr [coreParamsPkg::NUM_RF_READS];
    uopTypesPkg::Data_t rfReadData [coreParamsPkg::NUM_RF_READS];

    exUopIf exUop [coreParamsPkg::NUM_PORTS] ();
    resultIf aluFwd [coreParamsPkg::NUM_PORTS] ();
    resultIf exOut [coreParamsPkg::NUM_PORTS] ();
    resultIf wb [coreParamsPkg::NUM_PORTS] ();

    for (genvar g = 0; g < coreParamsPkg::NUM_PORTS; g++) begin : gPort
        assign issueUop[g] = '{
            tagA: issueTagA[g],
            tagB: issueTagB[g],
            tagDst: issueTagDst[g],
            imm: issueImm[g],
            immB: issueImmB[g],
            opcode: issueOpcode[g],
            fu: issueFu[g],
            sqN: issueSqN[g]
        };

        // Operand fetch holds its output, so the issue port waits too
        assign issueStall[g] = exUop[g].stall;

        assign wbValid[g] = wb[g].valid;
        assign wbTag[g] = wb[g].tag;
        assign wbResult[g] = wb[g].result;
        assign wbSqN[g] = wb[g].sqN;

        execUnit iExec (
            .clk(clk),
            .rst(rst),
            .exUop(exUop[g]),
            .flush(flush),
            .flushSqN(flushSqN),
            .aluFwd(aluFwd[g]),
            .exOut(exOut[g])
        );
    end

    regFile iRegFile (
        .clk(clk),
        .rst(rst),
        .readAddr(rfReadAddr),
        .readData(rfReadData),
        .wb(wb)
    );

    operandLoad iOperandLoad (
        .clk(clk),
        .rst(rst),
        .uopValid(issueValid),
        .uop(issueUop),
        .flush(flush),
        .flushSqN(flushSqN),
        .rfReadAddr(rfReadAddr),
        .rfReadData(rfReadData),
        .aluFwd(aluFwd),
        .exOut(exOut),
        .wb(wb),
        .exUop(exUop)
    );

    writebackStage iWriteback (
        .clk(clk),
        .rst(rst),
        .exOut(exOut),
        .flush(flush),
        .flushSqN(flushSqN),
        .wb(wb)
    );

endmodule

`default_nettype wire

/* dv/backendCore_assertions.sv */
`default_nettype none

module backendCoreAssertions (
    input logic clk,
    input logic rst,
    input logic issueStall [coreParamsPkg::NUM_PORTS],
    input logic wbValid [coreParamsPkg::NUM_PORTS],
    input uopTypesPkg::Tag_t wbTag [coreParamsPkg::NUM_PORTS]
);
    timeunit 1ns;
    timeprecision 1ps;

    for (genvar g = 0; g < coreParamsPkg::NUM_PORTS; g++) begin : gPort
        // Collision stall lasts a single cycle
        stallShort: assert property (@(posedge clk) disable iff (rst)
            issueStall[g] |=> !issueStall[g])
            else $error("issueStall high two cycles in a row on port %0d", g);

        // Results only go to real registers
        tagIsReg: assert property (@(posedge clk) disable iff (rst)
            wbValid[g] |-> !wbTag[g][coreParamsPkg::TAG_W-1])
            else $error("constant tag on the wb bus of port %0d", g);

        quietAfterReset: assert property (@(posedge clk)
            rst |=> !wbValid[g] && !issueStall[g])
            else $error("valid or stall high right after reset on port %0d", g);
    end

endmodule

bind backendCore backendCoreAssertions iAssertions (
    .clk(clk),
    .rst(rst),
    .issueStall(issueStall),
    .wbValid(wbValid),
    .wbTag(wbTag)
);

`default_nettype wire

/* dv/backendCoreTb.sv */
`default_nettype none

module backendCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    // The tests need about 90 cycles
    localparam int TIMEOUT_CYCLES = 200;

    typedef struct {
        uopTypesPkg::Tag_t tag;
        uopTypesPkg::Data_t result;
        uopTypesPkg::SqN_t sqN;
        int cycle;
        int lat;
        logic keep;
    } Expect_t;

    logic clk = 1'b0;
    logic rst;
    logic issueValid [2];
    uopTypesPkg::Tag_t issueTagA [2];
    uopTypesPkg::Tag_t issueTagB [2];
    uopTypesPkg::Tag_t issueTagDst [2];
    uopTypesPkg::Data_t issueImm [2];
    logic issueImmB [2];
    uopTypesPkg::AluOp_t issueOpcode [2];
    uopTypesPkg::FuncUnit_t issueFu [2];
    uopTypesPkg::SqN_t issueSqN [2];
    logic issueStall [2];
    logic wbValid [2];
    uopTypesPkg::Tag_t wbTag [2];
    uopTypesPkg::Data_t wbResult [2];
    uopTypesPkg::SqN_t wbSqN [2];
    logic flush;
    uopTypesPkg::SqN_t flushSqN;

    uopTypesPkg::Data_t modelReg [64];
    Expect_t expQ [2][$];
    Expect_t pendOp [2];
    logic pending [2];
    int stallCount [2];
    int cycle = 0;
    string testName = "reset";
    logic [31:0] lcgState = 32'd74475;
    uopTypesPkg::SqN_t nextSqN = '0;

    backendCore i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: results still outstanding after %0d cycles", cycle);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected 0x%0h actual 0x%0h",
                     testName, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Every wb result must be the oldest expected one of its port
    always @(negedge clk) begin
        Expect_t e;
        if (!rst) begin
            for (int p = 0; p < 2; p++) begin
                if (wbValid[p]) begin
                    if (expQ[p].size() == 0) begin
                        $display("Unexpected result on wb port %0d during %s", p, testName);
                        $display("Regression failed");
                        $fatal(1, "unexpected result");
                    end
                    e = expQ[p].pop_front();
                    checkValue("wbTag", 32'(e.tag), 32'(wbTag[p]));
                    checkValue("wbResult", e.result, wbResult[p]);
                    checkValue("wbSqN", 32'(e.sqN), 32'(wbSqN[p]));
                    if (e.lat != 0) begin
                        checkValue("latency", e.lat, cycle - e.cycle);
                    end
                end
            end
        end
    end

    function automatic logic [31:0] lcg();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    function automatic uopTypesPkg::Tag_t constTag(int v);
        return {1'b1, 6'(v)};
    endfunction

    function automatic uopTypesPkg::Tag_t regTag(int r);
        return {1'b0, 6'(r)};
    endfunction

    function automatic uopTypesPkg::Data_t operandValue(uopTypesPkg::Tag_t t);
        if (t[6]) begin
            return {{26{t[5]}}, t[5:0]};
        end
        return modelReg[t[5:0]];
    endfunction

    function automatic uopTypesPkg::Data_t computeResult(uopTypesPkg::AluOp_t op,
                                                        uopTypesPkg::Data_t a,
                                                        uopTypesPkg::Data_t b);
        logic signed [63:0] prod;
        prod = 64'(signed'(a)) * 64'(signed'(b));
        case (op)
            uopTypesPkg::ADD: return a + b;
            uopTypesPkg::SUB: return a - b;
            uopTypesPkg::AND: return a & b;
            uopTypesPkg::OR: return a | b;
            uopTypesPkg::XOR: return a ^ b;
            uopTypesPkg::SLL: return a << b[4:0];
            uopTypesPkg::SRL: return a >> b[4:0];
            uopTypesPkg::MUL: return prod[31:0];
            default: return prod[63:32];
        endcase
    endfunction

    // Present one op; the model sees it in program order
    task automatic driveOp(int p, uopTypesPkg::Tag_t a, uopTypesPkg::Tag_t b,
                           int dst, uopTypesPkg::Data_t imm, logic immB,
                           uopTypesPkg::AluOp_t op, int lat, logic keep = 1'b1);
        Expect_t e;
        logic isMul;
        isMul = (op == uopTypesPkg::MUL) || (op == uopTypesPkg::MULH);
        e.tag = regTag(dst);
        e.result = computeResult(op, operandValue(a), immB ? imm : operandValue(b));
        e.sqN = nextSqN;
        e.lat = lat;
        e.keep = keep;
        if (keep) begin
            modelReg[dst] = e.result;
        end
        pendOp[p] = e;
        pending[p] = 1'b1;
        issueValid[p] <= 1'b1;
        issueTagA[p] <= a;
        issueTagB[p] <= b;
        issueTagDst[p] <= regTag(dst);
        issueImm[p] <= imm;
        issueImmB[p] <= immB;
        issueOpcode[p] <= op;
        issueFu[p] <= isMul ? uopTypesPkg::FU_MUL : uopTypesPkg::FU_INT;
        issueSqN[p] <= nextSqN;
        nextSqN++;
    endtask

    // Hold each driven op until the DUT takes it
    task automatic waitAccept();
        logic accepted [2];
        while (pending[0] || pending[1]) begin
            @(negedge clk);
            for (int p = 0; p < 2; p++) begin
                accepted[p] = pending[p] && !issueStall[p];
                if (pending[p] && issueStall[p]) begin
                    stallCount[p]++;
                end
                if (accepted[p]) begin
                    pendOp[p].cycle = cycle + 1;
                    if (pendOp[p].keep) begin
                        expQ[p].push_back(pendOp[p]);
                    end
                end
            end
            @(posedge clk);
            for (int p = 0; p < 2; p++) begin
                if (accepted[p]) begin
                    issueValid[p] <= 1'b0;
                    pending[p] = 1'b0;
                end
            end
        end
    endtask

    task automatic waitDrain();
        while (expQ[0].size() != 0 || expQ[1].size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic testReset();
        testName = "reset";
        @(negedge clk);
        checkValue("wbValid[0]", 0, wbValid[0]);
        checkValue("wbValid[1]", 0, wbValid[1]);
        checkValue("issueStall[0]", 0, issueStall[0]);
        checkValue("issueStall[1]", 0, issueStall[1]);
        @(posedge clk);
        driveOp(0, regTag(7), constTag(0), 50, 0, 0, uopTypesPkg::ADD, 2);
        driveOp(1, regTag(33), regTag(9), 51, 0, 0, uopTypesPkg::OR, 2);
        waitAccept();
        waitDrain();
    endtask

    task automatic testConstants();
        testName = "constants";
        driveOp(0, constTag(5), constTag(-3), 1, 0, 0, uopTypesPkg::ADD, 2);
        driveOp(1, constTag(-1), regTag(0), 2, 32'd100, 1, uopTypesPkg::SUB, 2);
        waitAccept();
        driveOp(0, regTag(1), regTag(0), 3, 32'd4, 1, uopTypesPkg::SLL, 2);
        driveOp(1, constTag(7), regTag(0), 4, 32'h5a5a, 1, uopTypesPkg::XOR, 2);
        waitAccept();
        waitDrain();
    endtask

    task automatic testForwarding();
        testName = "forwarding";
        driveOp(0, regTag(1), regTag(3), 10, 0, 0, uopTypesPkg::OR, 2);
        driveOp(1, regTag(2), constTag(-8), 11, 0, 0, uopTypesPkg::AND, 2);
        waitAccept();
        // Back-to-back consumers read aluFwd of both ports
        driveOp(0, regTag(10), regTag(11), 12, 0, 0, uopTypesPkg::ADD, 2);
        driveOp(1, regTag(11), regTag(1), 13, 0, 0, uopTypesPkg::SUB, 2);
        waitAccept();
        // Two edges later both producers sit on exOut
        @(posedge clk);
        driveOp(1, regTag(12), regTag(13), 16, 0, 0, uopTypesPkg::SUB, 2);
        waitAccept();
        driveOp(0, regTag(12), regTag(13), 14, 0, 0, uopTypesPkg::XOR, 2);
        waitAccept();
        waitDrain();
        driveOp(1, regTag(14), regTag(10), 15, 0, 0, uopTypesPkg::ADD, 2);
        waitAccept();
        waitDrain();
    endtask

    task automatic testMultiply();
        testName = "multiply";
        stallCount[0] = 0;
        driveOp(0, regTag(3), regTag(4), 20, 0, 0, uopTypesPkg::MUL, 3);
        waitAccept();
        // Held behind the multiplier for one extra cycle
        driveOp(0, regTag(1), constTag(1), 21, 0, 0, uopTypesPkg::ADD, 3);
        waitAccept();
        driveOp(0, regTag(2), regTag(1), 22, 0, 0, uopTypesPkg::OR, 2);
        // Product forwarded from multiplier stage 1 of port 0
        driveOp(1, regTag(20), constTag(1), 25, 0, 0, uopTypesPkg::ADD, 2);
        waitAccept();
        checkValue("stall cycles", 1, stallCount[0]);
        waitDrain();
        driveOp(1, constTag(3), regTag(0), 24, 32'h8000_0123, 1, uopTypesPkg::ADD, 2);
        waitAccept();
        driveOp(1, regTag(24), regTag(24), 23, 0, 0, uopTypesPkg::MULH, 3);
        waitAccept();
        waitDrain();
    endtask

    task automatic testFlush();
        uopTypesPkg::SqN_t midSqN;
        testName = "flush";
        driveOp(0, regTag(4), constTag(9), 40, 0, 0, uopTypesPkg::ADD, 2);
        waitAccept();
        midSqN = nextSqN;
        driveOp(0, regTag(3), constTag(2), 41, 0, 0, uopTypesPkg::SUB, 2);
        waitAccept();
        driveOp(0, constTag(11), constTag(12), 1, 0, 0, uopTypesPkg::ADD, 0, 1'b0);
        waitAccept();
        driveOp(0, constTag(13), constTag(14), 2, 0, 0, uopTypesPkg::XOR, 0, 1'b0);
        waitAccept();
        flush <= 1'b1;
        flushSqN <= midSqN;
        @(posedge clk);
        flush <= 1'b0;
        waitDrain();
        driveOp(0, regTag(1), constTag(0), 42, 0, 0, uopTypesPkg::ADD, 2);
        driveOp(1, regTag(2), constTag(0), 43, 0, 0, uopTypesPkg::ADD, 2);
        waitAccept();
        waitDrain();
    endtask

    task automatic testRandom();
        logic [31:0] r;
        uopTypesPkg::Tag_t srcA;
        uopTypesPkg::Tag_t srcB;
        testName = "random";
        for (int i = 0; i < 20; i++) begin
            for (int p = 0; p < 2; p++) begin
                r = lcg();
                srcA = r[0] ? constTag(int'(r[11:6])) : regTag(int'(r[4:0]));
                srcB = r[1] ? constTag(int'(r[17:12])) : regTag(int'(r[22:18]));
                driveOp(p, srcA, srcB, 32 + (2 * i + p) % 32, lcg(), r[23],
                        uopTypesPkg::AluOp_t'(r[31:24] % 7), 2);
            end
            waitAccept();
        end
        waitDrain();
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        flushSqN = '0;
        for (int p = 0; p < 2; p++) begin
            issueValid[p] = 1'b0;
            issueTagA[p] = '0;
            issueTagB[p] = '0;
            issueTagDst[p] = '0;
            issueImm[p] = '0;
            issueImmB[p] = 1'b0;
            issueOpcode[p] = uopTypesPkg::ADD;
            issueFu[p] = uopTypesPkg::FU_INT;
            issueSqN[p] = '0;
            pending[p] = 1'b0;
            stallCount[p] = 0;
        end
        for (int r = 0; r < 64; r++) begin
            modelReg[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        testReset();
        testConstants();
        testForwarding();
        testMultiply();
        testFlush();
        testRandom();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* backendCore.f */
design/coreParamsPkg.sv
design/uopTypesPkg.sv
design/backendIfs.sv
design/regFile.sv
design/operandLoad.sv
design/execUnit.sv
design/writebackStage.sv
design/backendCore.sv
dv/backendCore_assertions.sv
dv/backendCoreTb.sv

/* Makefile */
sim:
	verilator --binary --timing --assert --top-module backendCoreTb \
		-f backendCore.f -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

.PHONY: sim clean
